// File: Makefile
# Verilator build for the system top and its testbench

VERILATOR ?= verilator
FILELIST  ?= sys.f
TB_TOP    ?= tb_sys_top
RTL_TOP   ?= sys_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= sim passed
VFLAGS    ?= --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/audio_mixer.sv
// Audio mixer, one channel
// Stable core sample filter, host sample mix, stereo cross-feed,
// attenuation and clamping to 16 bits

`timescale 1ns/100ps

module audio_mixer
	import sys_pkg::*;
(
	input  logic        clk,
	input  audio_cfg_t  i_cfg,
	input  logic [15:0] i_core,
	input  sample_t     i_host,
	input  sample_t     i_pre_other,
	output sample_t     o_pre,
	output sample_t     o_out
);

	logic [15:0]        core_d1;
	logic [15:0]        core_d2;
	logic [15:0]        core_hold;
	logic signed [16:0] a1;
	logic signed [16:0] a2;
	logic signed [16:0] a3;
	logic signed [16:0] a4;
	logic signed [16:0] host_ext;
	logic signed [16:0] pre_ext;

	////////////////////////////////////////
	// Core sample filter
	////////////////////////////////////////

	// Take the core sample only once two samplings agree
	always_ff @(posedge clk) begin
		core_d1 <= i_core;
		core_d2 <= core_d1;
		if (core_d1 == core_d2) begin
			core_hold <= core_d1;
		end
	end

	////////////////////////////////////////
	// Mix pipeline
	////////////////////////////////////////

	// Offset binary is halved so it fits next to the host sample
	assign a1 = i_cfg.is_signed ? {core_hold[15], core_hold} : {2'b00, core_hold[15:1]};

	assign host_ext = {i_host[15], i_host};
	assign pre_ext  = {i_pre_other[15], i_pre_other};

	always_ff @(posedge clk) begin
		a2 <= a1 + host_ext;

		// Cross-feed with the other channel
		case (i_cfg.mix)
			2'd0: a3 <= a2;
			2'd1: a3 <= a2 - (a2 >>> 3) + (pre_ext >>> 2);
			2'd2: a3 <= a2 - (a2 >>> 2) + (pre_ext >>> 1);
			default: a3 <= (a2 >>> 1) + pre_ext;
		endcase

		if (i_cfg.att[4]) begin
			a4 <= '0;
		end else begin
			a4 <= a3 >>> i_cfg.att[3:0];
		end

		// Saturate when bits 16 and 15 disagree
		if (a4[16] != a4[15]) begin
			o_out <= {a4[16], {15{~a4[16]}}};
		end else begin
			o_out <= a4[15:0];
		end
	end

	assign o_pre = a2[16:1];

endmodule

// File: source/csync_gen.sv
// Composite sync generator
// Measures line and hsync length, builds composite sync during vsync
// and selects the registered VGA hsync output

`timescale 1ns/100ps

module csync_gen #(
	parameter int LINE_CNT_W = 16
)
(
	input  logic clk,
	input  logic i_csync_en,
	input  logic i_hs,
	input  logic i_vs,
	output logic o_hs,
	output logic o_vs
);

	logic                  prev_hs;
	logic [LINE_CNT_W-1:0] h_cnt;
	logic [LINE_CNT_W-1:0] line_len;
	logic [LINE_CNT_W-1:0] hs_len;
	logic                  shift_hs;
	logic                  composite;

	always_ff @(posedge clk) begin
		prev_hs <= i_hs;

		// Length of the current hsync run
		if (prev_hs != i_hs) begin
			h_cnt <= '0;
			if (i_hs) begin
				line_len <= h_cnt - hs_len;
			end else begin
				hs_len <= h_cnt;
			end
		end else if (~&h_cnt) begin
			h_cnt <= h_cnt + 1'b1;
		end

		// Pulse moved one hsync width ahead of the next hsync
		if (i_hs & ~prev_hs) begin
			shift_hs <= 1'b0;
		end else if (h_cnt == line_len) begin
			shift_hs <= 1'b1;
		end

		o_hs <= i_csync_en ? composite : i_hs;
	end

	// Serrated pulses inside vsync
	assign composite = i_vs ? (i_vs ^ shift_hs) : i_hs;

	assign o_vs = i_vs;

endmodule

// File: source/host_cmd_ctrl.sv
// Host command port controller
// Four-phase req/ack handshake, command framing and decoding,
// configuration, LED and volume registers, main-board LED select

`timescale 1ns/100ps

module host_cmd_ctrl
	import sys_pkg::*;
(
	input  logic       clk,
	input  logic       resetd,

	input  logic       i_io_ss,
	input  logic       i_io_req,
	input  io_word_t   i_io_din,

	input  logic       i_led_user,
	input  logic       i_led_disk,
	input  logic       i_led_power,

	output logic       o_io_ack,
	output audio_cfg_t o_audio_cfg,
	output logic       o_csync_en,
	output led_t       o_led
);

	logic       io_strobe;
	logic       has_cmd;
	cmd_code_t  cmd;
	io_word_t   cfg;
	led_t       led_mask;
	led_t       led_state;
	logic [4:0] vol_att;
	led_t       led_status;

	////////////////////////////////////////
	// Handshake
	////////////////////////////////////////

	// New word on request while ack is still low
	assign io_strobe = i_io_req & ~o_io_ack;

	always_ff @(posedge clk) begin
		if (resetd) begin
			o_io_ack <= 1'b0;
		end else if (io_strobe) begin
			o_io_ack <= 1'b1;
		end else if (!i_io_req) begin
			o_io_ack <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Framing and register writes
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			has_cmd   <= 1'b0;
			cmd       <= '0;
			cfg       <= '0;
			led_mask  <= '0;
			led_state <= '0;
			vol_att   <= '0;
		end else if (!i_io_ss) begin
			// Frame closed, next word is a command again
			has_cmd <= 1'b0;
			cmd     <= '0;
		end else if (io_strobe) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= i_io_din[7:0];
			end else begin
				case (cmd)
					CMD_CFG: cfg <= i_io_din;
					CMD_LED: {led_mask, led_state} <= i_io_din;
					CMD_VOL: vol_att <= i_io_din[4:0];
					default: ;
				endcase
			end
		end
	end

	////////////////////////////////////////
	// Outputs
	////////////////////////////////////////

	always_comb begin
		o_audio_cfg.att       = vol_att;
		o_audio_cfg.mix       = mix_mode_t'(cfg[CFG_MIX_LSB +: 2]);
		o_audio_cfg.is_signed = cfg[CFG_IS_SIGNED_BIT];
	end

	assign o_csync_en = cfg[CFG_CSYNC_BIT];

	// Status on bits 0, 2 and 4 when not overridden
	assign led_status = {3'b000, i_led_power, 1'b0, i_led_disk, 1'b0, i_led_user};

	assign o_led = (led_mask & led_state) | (~led_mask & led_status);

endmodule

// File: source/sync_polarity_fix.sv
// Sync polarity correction
// Times high and low runs and inverts the sync when its pulse is low

`timescale 1ns/100ps

module sync_polarity_fix #(
	parameter int LINE_CNT_W = 16
)
(
	input  logic clk,
	input  logic i_sync,
	output logic o_sync
);

	logic                  sync_s1;
	logic                  sync_s2;
	logic [LINE_CNT_W-1:0] run_cnt;
	logic [LINE_CNT_W-1:0] high_len;
	logic [LINE_CNT_W-1:0] low_len;
	logic                  pol;

	always_ff @(posedge clk) begin
		sync_s1 <= i_sync;
		sync_s2 <= sync_s1;

		// Run length, restarts on every transition and holds at the top
		if (sync_s1 != sync_s2) begin
			run_cnt <= '0;
		end else if (~&run_cnt) begin
			run_cnt <= run_cnt + 1'b1;
		end

		if (sync_s1 & ~sync_s2) begin
			low_len <= run_cnt;
		end
		if (~sync_s1 & sync_s2) begin
			high_len <= run_cnt;
		end

		// Longer high run means the pulse is active low
		pol <= high_len > low_len;
	end

	assign o_sync = i_sync ^ pol;

endmodule

// File: source/sys_pkg.sv
// Shared definitions for the system top
// Host port word and command codes, audio sample and settings types,
// LED vector and configuration word bit positions

package sys_pkg;

	////////////////////////////////////////
	// Host command port
	////////////////////////////////////////

	typedef logic [15:0] io_word_t;

	// Command byte from the low byte of the first frame word
	typedef logic [7:0] cmd_code_t;

	localparam cmd_code_t CMD_CFG = 8'h01;
	localparam cmd_code_t CMD_LED = 8'h25;
	localparam cmd_code_t CMD_VOL = 8'h26;

	// Bit positions inside the configuration word
	localparam int CFG_IS_SIGNED_BIT = 0;
	localparam int CFG_MIX_LSB       = 1;
	localparam int CFG_CSYNC_BIT     = 3;

	////////////////////////////////////////
	// Audio
	////////////////////////////////////////

	typedef logic signed [15:0] sample_t;

	// Cross-feed: 0 none, 1 quarter, 2 half, 3 full mono
	typedef logic [1:0] mix_mode_t;

	typedef struct packed {
		// Bit 4 mutes, bits 3..0 are the right shift count
		logic [4:0] att;
		mix_mode_t  mix;
		// Core samples in two's complement, else offset binary
		logic       is_signed;
	} audio_cfg_t;

	////////////////////////////////////////
	// LEDs
	////////////////////////////////////////

	typedef logic [7:0] led_t;

endpackage

// File: source/sys_top.sv
// System top level
// Host command control, stereo audio mixer pair,
// sync polarity correction and composite sync output

`timescale 1ns/100ps

module sys_top
	import sys_pkg::*;
#(
	parameter int LINE_CNT_W = 16
)
(
	input  logic        clk,
	input  logic        resetd,

	// Host command port
	input  logic        i_io_ss,
	input  logic        i_io_req,
	input  io_word_t    i_io_din,
	output logic        o_io_ack,

	// Audio
	input  logic [15:0] i_core_l,
	input  logic [15:0] i_core_r,
	input  sample_t     i_host_l,
	input  sample_t     i_host_r,
	output sample_t     o_audio_l,
	output sample_t     o_audio_r,

	// Video sync
	input  logic        i_hs,
	input  logic        i_vs,
	output logic        o_vga_hs,
	output logic        o_vga_vs,

	// LEDs
	input  logic        i_led_user,
	input  logic        i_led_disk,
	input  logic        i_led_power,
	output led_t        o_led
);

	audio_cfg_t audio_cfg;
	logic       csync_en;
	sample_t    pre_l;
	sample_t    pre_r;
	logic       hs_fix;
	logic       vs_fix;

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	host_cmd_ctrl host_cmd_ctrl (
		.clk         (clk),
		.resetd      (resetd),
		.i_io_ss     (i_io_ss),
		.i_io_req    (i_io_req),
		.i_io_din    (i_io_din),
		.i_led_user  (i_led_user),
		.i_led_disk  (i_led_disk),
		.i_led_power (i_led_power),
		.o_io_ack    (o_io_ack),
		.o_audio_cfg (audio_cfg),
		.o_csync_en  (csync_en),
		.o_led       (o_led)
	);

	////////////////////////////////////////
	// Audio
	////////////////////////////////////////

	// Each channel feeds its pre-mix sample to the other for cross-feed
	audio_mixer audmix_l (
		.clk         (clk),
		.i_cfg       (audio_cfg),
		.i_core      (i_core_l),
		.i_host      (i_host_l),
		.i_pre_other (pre_r),
		.o_pre       (pre_l),
		.o_out       (o_audio_l)
	);

	audio_mixer audmix_r (
		.clk         (clk),
		.i_cfg       (audio_cfg),
		.i_core      (i_core_r),
		.i_host      (i_host_r),
		.i_pre_other (pre_l),
		.o_pre       (pre_r),
		.o_out       (o_audio_r)
	);

	////////////////////////////////////////
	// Video sync
	////////////////////////////////////////

	sync_polarity_fix #(.LINE_CNT_W(LINE_CNT_W)) sync_h (
		.clk    (clk),
		.i_sync (i_hs),
		.o_sync (hs_fix)
	);

	sync_polarity_fix #(.LINE_CNT_W(LINE_CNT_W)) sync_v (
		.clk    (clk),
		.i_sync (i_vs),
		.o_sync (vs_fix)
	);

	csync_gen #(.LINE_CNT_W(LINE_CNT_W)) csync_gen (
		.clk        (clk),
		.i_csync_en (csync_en),
		.i_hs       (hs_fix),
		.i_vs       (vs_fix),
		.o_hs       (o_vga_hs),
		.o_vs       (o_vga_vs)
	);

endmodule

// File: sys.f
source/sys_pkg.sv
source/host_cmd_ctrl.sv
source/audio_mixer.sv
source/sync_polarity_fix.sv
source/csync_gen.sv
source/sys_top.sv
+incdir+testbench
testbench/tb_sys_top.sv

// File: testbench/tb_models.svh
// Testbench helpers for the system top
// Host port driver tasks, audio and LED reference models, compare tasks

`ifndef TB_MODELS_SVH
`define TB_MODELS_SVH

////////////////////////////////////////
// Host port driver
////////////////////////////////////////

// One word by the four-phase rule, starting and ending on a falling edge
task automatic send_word(input io_word_t w);
	int wait_cnt;
	@(negedge clk);
	if (o_io_ack !== 1'b0) begin
		$display("host port: ack still high before a new request");
		errors++;
	end
	i_io_din = w;
	i_io_req = 1'b1;
	wait_cnt = 0;
	while (o_io_ack !== 1'b1 && wait_cnt < WORD_BOUND) begin
		@(negedge clk);
		wait_cnt++;
	end
	if (o_io_ack !== 1'b1) begin
		$display("host port: ack never rose for word %h", w);
		errors++;
	end
	i_io_req = 1'b0;
	wait_cnt = 0;
	while (o_io_ack !== 1'b0 && wait_cnt < WORD_BOUND) begin
		@(negedge clk);
		wait_cnt++;
	end
	if (o_io_ack !== 1'b0) begin
		$display("host port: ack never fell after request dropped");
		errors++;
	end
	words_sent++;
endtask

task automatic host_write_frame(input cmd_code_t cmd, input io_word_t data);
	@(negedge clk);
	i_io_ss = 1'b1;
	send_word({8'h00, cmd});
	send_word(data);
	@(negedge clk);
	i_io_ss = 1'b0;
endtask

////////////////////////////////////////
// Reference models
////////////////////////////////////////

function automatic int front_sum(input logic is_signed, input logic [15:0] core,
		input sample_t host);
	int a1;
	if (is_signed)
		a1 = int'($signed(core));
	else
		a1 = int'(core >> 1);
	return a1 + int'(host);
endfunction

function automatic sample_t channel_out(input audio_cfg_t cfg, input int a2, input int pre);
	int a3;
	int a4;
	case (cfg.mix)
		2'd0: a3 = a2;
		2'd1: a3 = a2 - (a2 >>> 3) + (pre >>> 2);
		2'd2: a3 = a2 - (a2 >>> 2) + (pre >>> 1);
		default: a3 = (a2 >>> 1) + pre;
	endcase
	a4 = cfg.att[4] ? 0 : (a3 >>> cfg.att[3:0]);
	if (a4 > 32767) a4 = 32767;
	if (a4 < -32768) a4 = -32768;
	return sample_t'(a4);
endfunction

// Both channels, each taking half of the other's sum for cross-feed
function automatic void mix_model(input audio_cfg_t cfg, input logic [15:0] core_l,
		input logic [15:0] core_r, input sample_t host_l, input sample_t host_r,
		output sample_t out_l, output sample_t out_r);
	int sum_l;
	int sum_r;
	sum_l = front_sum(cfg.is_signed, core_l, host_l);
	sum_r = front_sum(cfg.is_signed, core_r, host_r);
	out_l = channel_out(cfg, sum_l, sum_r >>> 1);
	out_r = channel_out(cfg, sum_r, sum_l >>> 1);
endfunction

function automatic led_t led_model(input led_t mask, input led_t state, input logic user,
		input logic disk, input logic power);
	led_t status;
	led_t res;
	status    = '0;
	status[0] = user;
	status[2] = disk;
	status[4] = power;
	for (int i = 0; i < 8; i++)
		res[i] = mask[i] ? state[i] : status[i];
	return res;
endfunction

////////////////////////////////////////
// Compare tasks
////////////////////////////////////////

task automatic check_sample(input string name, input sample_t exp, input sample_t act);
	checks++;
	if (act !== exp) begin
		$display("error %s: expected %h, actual %h", name, exp, act);
		errors++;
	end
endtask

task automatic check_led(input string name, input led_t exp, input led_t act);
	checks++;
	if (act !== exp) begin
		$display("error %s: expected %h, actual %h", name, exp, act);
		errors++;
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	checks++;
	if (act !== exp) begin
		$display("error %s: expected %b, actual %b", name, exp, act);
		errors++;
	end
endtask

`endif

// File: testbench/tb_sys_top.sv
// Testbench for the system top
// Host handshake, LED override, framing, audio mix and sync output tests

`timescale 1ns/100ps

module tb_sys_top
	import sys_pkg::*;
();

	localparam int CLK_PERIOD  = 20;
	localparam int WORD_BOUND  = 10;
	localparam int N_HS_WORDS  = 16;
	localparam int N_LED       = 16;
	localparam int N_AUDIO     = 32;
	localparam int AUDIO_WAIT  = 20;
	localparam int V_FRAMES    = 5;
	localparam int V_LINES     = 8;
	localparam int MAX_LINE    = 72;
	localparam int N_WORDS     = N_HS_WORDS + 2 * N_LED + 6 + 4 * N_AUDIO + 2 * 8 + 2;
	localparam int AUDIO_CYC   = (N_AUDIO + 2) * AUDIO_WAIT;
	localparam int VIDEO_CYC   = 8 * V_FRAMES * V_LINES * MAX_LINE;
	localparam int LIMIT_CYC   = (N_WORDS * WORD_BOUND + AUDIO_CYC + VIDEO_CYC + 10) * 3 / 2;

	logic        clk;
	logic        resetd;
	logic        i_io_ss;
	logic        i_io_req;
	io_word_t    i_io_din;
	logic        o_io_ack;
	logic [15:0] i_core_l;
	logic [15:0] i_core_r;
	sample_t     i_host_l;
	sample_t     i_host_r;
	sample_t     o_audio_l;
	sample_t     o_audio_r;
	logic        i_hs;
	logic        i_vs;
	logic        o_vga_hs;
	logic        o_vga_vs;
	logic        i_led_user;
	logic        i_led_disk;
	logic        i_led_power;
	led_t        o_led;

	int          errors;
	int          checks;
	int          words_sent;
	audio_cfg_t  cur_cfg;
	led_t        cur_mask;
	led_t        cur_state;

	sys_top #(.LINE_CNT_W(16)) uut (.*);

	`include "tb_models.svh"

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Watchdog
	initial begin
		#(LIMIT_CYC * CLK_PERIOD);
		$display("timeout: the run did not finish in %0d cycles", LIMIT_CYC);
		$display("sim failed");
		$finish;
	end

	task automatic check_audio(input string name);
		sample_t exp_l;
		sample_t exp_r;
		mix_model(cur_cfg, i_core_l, i_core_r, i_host_l, i_host_r, exp_l, exp_r);
		check_sample({name, " left"}, exp_l, o_audio_l);
		check_sample({name, " right"}, exp_r, o_audio_r);
	endtask

	task automatic write_cfg(input logic is_signed, input mix_mode_t mix, input logic csync);
		host_write_frame(CMD_CFG, {12'h000, csync, mix, is_signed});
		cur_cfg.is_signed = is_signed;
		cur_cfg.mix       = mix;
	endtask

	// Drives one sync pattern and checks the outputs after warm-up frames
	task automatic run_video(input logic hs_high, input logic vs_high, input logic csync_on);
		int   line_len;
		int   hs_w;
		int   diff_cnt;
		logic hs_act;
		logic vs_act;
		logic hs_last;
		logic vs_last;
		line_len = 40 + int'($urandom % 32);
		hs_w     = 4 + int'($urandom % 8);
		diff_cnt = 0;
		hs_last  = 1'b0;
		vs_last  = 1'b0;
		write_cfg(cur_cfg.is_signed, cur_cfg.mix, csync_on);
		for (int f = 0; f < V_FRAMES; f++)
			for (int ln = 0; ln < V_LINES; ln++)
				for (int c = 0; c < line_len; c++) begin
					@(negedge clk);
					if (f >= 3) begin
						check_bit("video vsync", vs_last, o_vga_vs);
						if (!csync_on || !vs_last)
							check_bit("video hsync", hs_last, o_vga_hs);
						else if (o_vga_hs !== hs_last)
							diff_cnt++;
					end
					hs_act  = c < hs_w;
					vs_act  = ln < 2;
					i_hs    = hs_high ? hs_act : ~hs_act;
					i_vs    = vs_high ? vs_act : ~vs_act;
					hs_last = hs_act;
					vs_last = vs_act;
				end
		if (csync_on && diff_cnt == 0) begin
			$display("video: composite sync never differed from hsync during vsync");
			errors++;
		end
	endtask

	initial begin
		led_t    data;
		logic    att_mute;
		io_word_t vol;
		errors      = 0;
		checks      = 0;
		words_sent  = 0;
		cur_cfg     = '0;
		cur_mask    = '0;
		cur_state   = '0;
		resetd      = 1'b1;
		i_io_ss     = 1'b0;
		i_io_req    = 1'b0;
		i_io_din    = '0;
		i_core_l    = '0;
		i_core_r    = '0;
		i_host_l    = '0;
		i_host_r    = '0;
		i_hs        = 1'b0;
		i_vs        = 1'b0;
		i_led_user  = 1'b0;
		i_led_disk  = 1'b0;
		i_led_power = 1'b0;
		void'($urandom(32'he7894e26));

		repeat (5) @(posedge clk);
		@(negedge clk);
		resetd = 1'b0;
		check_bit("reset ack", 1'b0, o_io_ack);

		// Handshake with bare words outside a frame
		for (int i = 0; i < N_HS_WORDS; i++)
			send_word(io_word_t'($urandom));

		// LED override
		for (int i = 0; i < N_LED; i++) begin
			data = led_t'($urandom);
			cur_mask  = led_t'($urandom);
			cur_state = data;
			host_write_frame(CMD_LED, {cur_mask, cur_state});
			{i_led_user, i_led_disk, i_led_power} = 3'($urandom);
			@(negedge clk);
			check_led("led override",
				led_model(cur_mask, cur_state, i_led_user, i_led_disk, i_led_power), o_led);
		end

		// Unknown command and words without frame select
		i_core_l = 16'($urandom);
		i_core_r = 16'($urandom);
		i_host_l = sample_t'($urandom);
		i_host_r = sample_t'($urandom);
		repeat (AUDIO_WAIT) @(negedge clk);
		check_audio("framing before");
		host_write_frame(8'h42, io_word_t'($urandom));
		send_word({8'h00, CMD_LED});
		send_word(16'hffff);
		send_word({8'h00, CMD_VOL});
		send_word(16'h0010);
		repeat (AUDIO_WAIT) @(negedge clk);
		check_led("framing led",
			led_model(cur_mask, cur_state, i_led_user, i_led_disk, i_led_power), o_led);
		check_audio("framing after");

		// Audio mix over all modes, both formats, mute and clamping
		for (int i = 0; i < N_AUDIO; i++) begin
			write_cfg(i[2], mix_mode_t'(i % 4), 1'b0);
			att_mute = ($urandom % 4) == 0;
			vol = {11'h000, att_mute, (i % 5 == 0) ? 4'($urandom) : 4'($urandom % 3)};
			// Clamping steps run at full scale
			if (i % 4 == 3)
				vol = '0;
			host_write_frame(CMD_VOL, vol);
			cur_cfg.att = vol[4:0];
			@(negedge clk);
			if (i % 4 == 3) begin
				i_core_l = i[3] ? 16'h7fff : 16'h8000;
				i_core_r = i[3] ? 16'h7fff : 16'h8000;
				i_host_l = i[3] ? 16'sh7fff : -16'sh7fff;
				i_host_r = i[3] ? 16'sh7f00 : -16'sh7f00;
			end else begin
				i_core_l = 16'($urandom);
				i_core_r = 16'($urandom);
				i_host_l = sample_t'($urandom);
				i_host_r = sample_t'($urandom);
			end
			repeat (AUDIO_WAIT) @(negedge clk);
			check_audio("audio mix");
		end

		// Sync polarity and composite sync
		for (int p = 0; p < 8; p++)
			run_video(p[0], p[1], p[2]);

		$display("errors: %0d, checks: %0d, words: %0d", errors, checks, words_sent);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule
